// File: hw/bus_pkg.sv
package bus_pkg;

    // ============================================================
    // sizes
    // ============================================================
    localparam int ADDR_W          = 32;
    localparam int WORD_W          = 32;
    localparam int LANES           = WORD_W / 8;
    localparam int BYTE_OFF_W      = $clog2(LANES);
    localparam int BYTES_PER_WORD  = LANES;
    localparam int MEM_WORDS       = 256;
    localparam int MEM_ADDR_W      = $clog2(MEM_WORDS);
    localparam int MEM_QUEUE_DEPTH = 4;
    localparam int QPTR_W          = $clog2(MEM_QUEUE_DEPTH);

    typedef logic [ADDR_W-1:0]                      addr_t;
    typedef logic [WORD_W-1:0]                      word_t;
    typedef logic [LANES-1:0]                       strobe_t;
    typedef logic [BYTE_OFF_W-1:0]                  offset_t;
    typedef logic [MEM_ADDR_W-1:0]                  word_idx_t;
    typedef logic [QPTR_W:0]                        qptr_t;    // extra bit tells full from empty.
    typedef logic [$clog2(MEM_QUEUE_DEPTH+1)-1:0]   credit_t;

    // legal access masks, right aligned.
    localparam strobe_t MASK_BYTE = 4'b0001;
    localparam strobe_t MASK_HALF = 4'b0011;
    localparam strobe_t MASK_WORD = 4'b1111;

    // ============================================================
    // bus payloads
    // ============================================================
    typedef enum logic {
        SRC_FETCH = 1'b0,
        SRC_LSU   = 1'b1
    } source_e;

    typedef struct packed {
        logic    write;
        addr_t   addr;      // always word aligned.
        word_t   data;
        strobe_t strobe;
        source_e source;
    } bus_req_t;

    typedef struct packed {
        word_t   data;
        source_e source;
    } bus_rsp_t;

endpackage

// File: hw/fetch_port.sv
`timescale 1ns/1ns

module fetch_port import bus_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     fetch_req,
    input  addr_t    fetch_pc,
    input  logic     grant,
    input  logic     rsp_valid,
    input  bus_rsp_t rsp,
    output logic     req_valid,
    output bus_req_t req,
    output logic     fetch_done,
    output logic     fetch_error,
    output word_t    instruction
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,
        FETCH_WAIT
    } fetch_state_e;

    fetch_state_e state;
    addr_t        pc_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= FETCH_IDLE;
            fetch_done  <= 1'b0;
            fetch_error <= 1'b0;
        end else begin
            fetch_done  <= 1'b0;
            fetch_error <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    if (fetch_req) begin
                        if (fetch_pc[BYTE_OFF_W-1:0] != '0) begin
                            fetch_done  <= 1'b1;   // misaligned pc never reaches the bus.
                            fetch_error <= 1'b1;
                        end else begin
                            state <= FETCH_REQUEST;
                        end
                    end
                end
                FETCH_REQUEST: if (grant) state <= FETCH_WAIT;
                FETCH_WAIT: begin
                    if (rsp_valid) begin
                        fetch_done <= 1'b1;
                        state      <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == FETCH_IDLE && fetch_req) pc_q <= fetch_pc;
        if (state == FETCH_WAIT && rsp_valid) instruction <= rsp.data;
    end

    assign req_valid  = (state == FETCH_REQUEST);
    assign req.write  = 1'b0;
    assign req.addr   = pc_q;
    assign req.data   = '0;
    assign req.strobe = MASK_WORD;
    assign req.source = SRC_FETCH;

endmodule

// File: hw/lsu_splitter.sv
`timescale 1ns/1ns

module lsu_splitter import bus_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     lsu_req,
    input  logic     lsu_write,
    input  addr_t    lsu_addr,
    input  word_t    lsu_wdata,
    input  strobe_t  lsu_mask,
    input  logic     grant,
    input  logic     rsp_valid,
    input  bus_rsp_t rsp,
    output logic     req_valid,
    output bus_req_t req,
    output logic     lsu_done,
    output logic     lsu_error,
    output word_t    lsu_rdata
);

    typedef enum logic [2:0] {
        LSU_IDLE,
        LSU_BEAT1,
        LSU_WAIT1,
        LSU_BEAT2,
        LSU_WAIT2
    } lsu_state_e;

    lsu_state_e          state;
    logic                write_q;
    addr_t               base_q;
    offset_t             offset_q;
    strobe_t             mask_q;
    logic                second_q;
    logic [2*WORD_W-1:0] data_wide_q;   // store data shifted into lane position.
    logic [2*LANES-1:0]  strb_wide_q;
    word_t               lo_word_q;

    logic                mask_legal;
    logic [2:0]          access_bytes;
    logic [2*WORD_W-1:0] merge_src;
    logic [2*WORD_W-1:0] merge_shifted;
    word_t               lane_keep;
    word_t               load_result;

    // ============================================================
    // access decode
    // ============================================================
    always_comb begin
        mask_legal = (lsu_mask == MASK_BYTE) || (lsu_mask == MASK_HALF) ||
                     (lsu_mask == MASK_WORD);
        case (lsu_mask)
            MASK_BYTE: access_bytes = 3'd1;
            MASK_HALF: access_bytes = 3'd2;
            default:   access_bytes = 3'd4;
        endcase
    end

    // ============================================================
    // load merge
    // ============================================================
    always_comb begin
        merge_src     = (state == LSU_WAIT2) ? {rsp.data, lo_word_q} : {word_t'(0), rsp.data};
        merge_shifted = merge_src >> {offset_q, 3'b000};
        for (int i = 0; i < LANES; i++) begin
            lane_keep[i*8 +: 8] = {8{mask_q[i]}};   // zero-extend to access size.
        end
        load_result = merge_shifted[WORD_W-1:0] & lane_keep;
    end

    // ============================================================
    // control
    // ============================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= LSU_IDLE;
            lsu_done  <= 1'b0;
            lsu_error <= 1'b0;
        end else begin
            lsu_done  <= 1'b0;
            lsu_error <= 1'b0;
            case (state)
                LSU_IDLE: begin
                    if (lsu_req) begin
                        if (!mask_legal) begin
                            lsu_done  <= 1'b1;
                            lsu_error <= 1'b1;
                        end else begin
                            state <= LSU_BEAT1;
                        end
                    end
                end
                LSU_BEAT1: begin
                    if (grant) begin
                        if (!write_q) state <= LSU_WAIT1;
                        else if (second_q) state <= LSU_BEAT2;
                        else begin
                            lsu_done <= 1'b1;   // write beat done at grant.
                            state    <= LSU_IDLE;
                        end
                    end
                end
                LSU_WAIT1: begin
                    if (rsp_valid) begin
                        if (second_q) state <= LSU_BEAT2;
                        else begin
                            lsu_done <= 1'b1;
                            state    <= LSU_IDLE;
                        end
                    end
                end
                LSU_BEAT2: begin
                    if (grant) begin
                        if (write_q) begin
                            lsu_done <= 1'b1;
                            state    <= LSU_IDLE;
                        end else begin
                            state <= LSU_WAIT2;
                        end
                    end
                end
                LSU_WAIT2: begin
                    if (rsp_valid) begin
                        lsu_done <= 1'b1;
                        state    <= LSU_IDLE;
                    end
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == LSU_IDLE && lsu_req) begin
            write_q     <= lsu_write;
            base_q      <= {lsu_addr[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
            offset_q    <= lsu_addr[BYTE_OFF_W-1:0];
            mask_q      <= lsu_mask;
            second_q    <= ({1'b0, lsu_addr[BYTE_OFF_W-1:0]} + access_bytes) > 3'(BYTES_PER_WORD);
            data_wide_q <= {word_t'(0), lsu_wdata} << {lsu_addr[BYTE_OFF_W-1:0], 3'b000};
            strb_wide_q <= {strobe_t'(0), lsu_mask} << lsu_addr[BYTE_OFF_W-1:0];
        end
        if (state == LSU_WAIT1 && rsp_valid) lo_word_q <= rsp.data;
        if ((state == LSU_WAIT1 && rsp_valid && !second_q) ||
            (state == LSU_WAIT2 && rsp_valid)) begin
            lsu_rdata <= load_result;
        end
    end

    assign req_valid  = (state == LSU_BEAT1) || (state == LSU_BEAT2);
    assign req.write  = write_q;
    assign req.addr   = (state == LSU_BEAT2) ? base_q + addr_t'(BYTES_PER_WORD) : base_q;
    assign req.data   = (state == LSU_BEAT2) ? data_wide_q[2*WORD_W-1:WORD_W]
                                             : data_wide_q[WORD_W-1:0];
    assign req.strobe = (state == LSU_BEAT2) ? strb_wide_q[2*LANES-1:LANES]
                                             : strb_wide_q[LANES-1:0];
    assign req.source = SRC_LSU;

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import bus_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     fetch_valid,
    input  bus_req_t fetch_req,
    input  logic     lsu_valid,
    input  bus_req_t lsu_req,
    input  logic     credit_return,
    input  logic     mem_rsp_valid,
    input  bus_rsp_t mem_rsp,
    output logic     fetch_grant,
    output logic     lsu_grant,
    output logic     mem_req_valid,
    output bus_req_t mem_req,
    output logic     fetch_rsp_valid,
    output logic     lsu_rsp_valid,
    output bus_rsp_t rsp
);

    credit_t credits;
    source_e last_winner;
    logic    have_credit;
    logic    pick_lsu;

    // ============================================================
    // round-robin choice, gated by credit
    // ============================================================
    always_comb begin
        have_credit = (credits != '0);
        pick_lsu    = lsu_valid && (!fetch_valid || last_winner == SRC_FETCH);
        lsu_grant   = have_credit && pick_lsu;
        fetch_grant = have_credit && fetch_valid && !pick_lsu;
    end

    assign mem_req_valid = fetch_grant || lsu_grant;
    assign mem_req       = lsu_grant ? lsu_req : fetch_req;

    always_ff @(posedge clock) begin
        if (reset) begin
            credits     <= credit_t'(MEM_QUEUE_DEPTH);
            last_winner <= SRC_LSU;   // fetch goes first on a tie.
        end else begin
            case ({mem_req_valid, credit_return})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
            if (lsu_grant) last_winner <= SRC_LSU;
            else if (fetch_grant) last_winner <= SRC_FETCH;
        end
    end

    // responses go back only to their owner.
    assign fetch_rsp_valid = mem_rsp_valid && (mem_rsp.source == SRC_FETCH);
    assign lsu_rsp_valid   = mem_rsp_valid && (mem_rsp.source == SRC_LSU);
    assign rsp             = mem_rsp;

endmodule

// File: hw/word_memory.sv
`timescale 1ns/1ns

module word_memory import bus_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     req_valid,
    input  bus_req_t req,
    output logic     credit_return,
    output logic     rsp_valid,
    output bus_rsp_t rsp
);

    bus_req_t  queue [MEM_QUEUE_DEPTH];
    word_t     mem   [MEM_WORDS];
    qptr_t     wr_ptr;
    qptr_t     rd_ptr;
    logic      queue_empty;
    bus_req_t  head;
    word_idx_t head_idx;

    assign queue_empty   = (wr_ptr == rd_ptr);
    assign head          = queue[rd_ptr[QPTR_W-1:0]];
    assign head_idx      = head.addr[MEM_ADDR_W+BYTE_OFF_W-1:BYTE_OFF_W];
    assign credit_return = !queue_empty;   // one credit per pop.

    // ============================================================
    // request queue
    // ============================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (req_valid) wr_ptr <= wr_ptr + qptr_t'(1);
            if (!queue_empty) rd_ptr <= rd_ptr + qptr_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid) queue[wr_ptr[QPTR_W-1:0]] <= req;
    end

    // ============================================================
    // word array
    // ============================================================
    always_ff @(posedge clock) begin
        if (!queue_empty && head.write) begin
            for (int i = 0; i < LANES; i++) begin
                if (head.strobe[i]) mem[head_idx][i*8 +: 8] <= head.data[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) rsp_valid <= 1'b0;
        else rsp_valid <= !queue_empty && !head.write;
    end

    always_ff @(posedge clock) begin
        if (!queue_empty && !head.write) begin
            rsp.data   <= mem[head_idx];
            rsp.source <= head.source;
        end
    end

endmodule

// File: hw/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top import bus_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    fetch_req,
    input  addr_t   fetch_pc,
    input  logic    lsu_req,
    input  logic    lsu_write,
    input  addr_t   lsu_addr,
    input  word_t   lsu_wdata,
    input  strobe_t lsu_mask,
    output logic    fetch_done,
    output logic    fetch_error,
    output word_t   instruction,
    output logic    lsu_done,
    output logic    lsu_error,
    output word_t   lsu_rdata
);

    logic     fetch_bus_valid;
    bus_req_t fetch_bus_req;
    logic     fetch_grant;
    logic     fetch_rsp_valid;
    logic     lsu_bus_valid;
    bus_req_t lsu_bus_req;
    logic     lsu_grant;
    logic     lsu_rsp_valid;
    bus_rsp_t port_rsp;
    logic     mem_req_valid;
    bus_req_t mem_req;
    logic     credit_return;
    logic     mem_rsp_valid;
    bus_rsp_t mem_rsp;

    fetch_port u_fetch (
        .clock(clock), .reset(reset),
        .fetch_req(fetch_req), .fetch_pc(fetch_pc),
        .grant(fetch_grant), .rsp_valid(fetch_rsp_valid), .rsp(port_rsp),
        .req_valid(fetch_bus_valid), .req(fetch_bus_req),
        .fetch_done(fetch_done), .fetch_error(fetch_error), .instruction(instruction)
    );

    lsu_splitter u_lsu (
        .clock(clock), .reset(reset),
        .lsu_req(lsu_req), .lsu_write(lsu_write), .lsu_addr(lsu_addr),
        .lsu_wdata(lsu_wdata), .lsu_mask(lsu_mask),
        .grant(lsu_grant), .rsp_valid(lsu_rsp_valid), .rsp(port_rsp),
        .req_valid(lsu_bus_valid), .req(lsu_bus_req),
        .lsu_done(lsu_done), .lsu_error(lsu_error), .lsu_rdata(lsu_rdata)
    );

    bus_arbiter u_arbiter (
        .clock(clock), .reset(reset),
        .fetch_valid(fetch_bus_valid), .fetch_req(fetch_bus_req),
        .lsu_valid(lsu_bus_valid), .lsu_req(lsu_bus_req),
        .credit_return(credit_return), .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
        .fetch_grant(fetch_grant), .lsu_grant(lsu_grant),
        .mem_req_valid(mem_req_valid), .mem_req(mem_req),
        .fetch_rsp_valid(fetch_rsp_valid), .lsu_rsp_valid(lsu_rsp_valid), .rsp(port_rsp)
    );

    word_memory u_memory (
        .clock(clock), .reset(reset),
        .req_valid(mem_req_valid), .req(mem_req),
        .credit_return(credit_return), .rsp_valid(mem_rsp_valid), .rsp(mem_rsp)
    );

endmodule

// File: verif/mem_subsystem_asserts.sv
`timescale 1ns/1ns

module mem_subsystem_asserts import bus_pkg::*; (
    input logic    clock,
    input logic    reset,
    input logic    fetch_grant,
    input logic    lsu_grant,
    input logic    mem_req_valid,
    input credit_t credits
);

    int unsigned assert_failures = 0;   // read by the testbench top at the end of the run.

    grants_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(fetch_grant && lsu_grant))
    else begin
        assert_failures++;
        $error("fetch and lsu granted in the same cycle");
    end

    credits_bounded: assert property (@(posedge clock) disable iff (reset)
        credits <= credit_t'(MEM_QUEUE_DEPTH))
    else begin
        assert_failures++;
        $error("credit count %0d above queue depth", credits);
    end

    // a request may only leave with a credit in hand.
    request_needs_credit: assert property (@(posedge clock) disable iff (reset)
        !(mem_req_valid && credits == '0))
    else begin
        assert_failures++;
        $error("memory request sent with no credit left");
    end

endmodule

// File: verif/mem_checker.sv
`timescale 1ns/1ns

module mem_checker import bus_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic [127:0] test_name,
    input  logic         fetch_req,
    input  addr_t        fetch_pc,
    input  logic         lsu_req,
    input  logic         lsu_write,
    input  addr_t        lsu_addr,
    input  word_t        lsu_wdata,
    input  strobe_t      lsu_mask,
    input  logic         fetch_done,
    input  logic         fetch_error,
    input  word_t        instruction,
    input  logic         lsu_done,
    input  logic         lsu_error,
    input  word_t        lsu_rdata,
    input  logic         run_done,
    output int           tests_failed
);

    logic [7:0] shadow [MEM_WORDS*BYTES_PER_WORD];   // byte image of what the stores wrote.
    logic       fetch_busy = 1'b0;
    logic       lsu_busy = 1'b0;
    logic       test_active = 1'b0;
    logic       test_bad = 1'b0;
    addr_t      pc_q;
    logic       write_q;
    addr_t      addr_q;
    word_t      wdata_q;
    strobe_t    mask_q;
    int         lsu_size;
    int         tests_run = 0;

    initial tests_failed = 0;

    function automatic int access_size(strobe_t mask);
        case (mask)
            MASK_BYTE: return 1;
            MASK_HALF: return 2;
            MASK_WORD: return 4;
            default:   return 0;
        endcase
    endfunction

    function automatic int byte_slot(addr_t addr);
        return int'(addr[MEM_ADDR_W+BYTE_OFF_W-1:0]);   // bits above the array wrap.
    endfunction

    function automatic word_t shadow_read(addr_t addr, int size);
        word_t value;
        value = '0;   // upper bytes stay zero.
        for (int i = 0; i < size; i++) begin
            value[i*8 +: 8] = shadow[byte_slot(addr + addr_t'(i))];
        end
        return value;
    endfunction

    task automatic compare(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %0s %0s: expected %h, actual %h",
                     test_name, what, expected, actual);
            test_bad = 1'b1;
        end
    endtask

    // ============================================================
    // completions first, then new requests
    // ============================================================
    always @(posedge clock) begin
        if (!reset) begin
            if (fetch_done && !fetch_busy) begin
                $display("%0s: fetch_done without a fetch request", test_name);
                test_bad = 1'b1;
            end
            if (lsu_done && !lsu_busy) begin
                $display("%0s: lsu_done without a load/store request", test_name);
                test_bad = 1'b1;
            end
            if (fetch_busy && fetch_done) begin
                fetch_busy = 1'b0;
                compare("fetch_error", word_t'(pc_q[BYTE_OFF_W-1:0] != '0), word_t'(fetch_error));
                if (pc_q[BYTE_OFF_W-1:0] == '0) begin
                    compare("instruction", shadow_read(pc_q, 4), instruction);
                end
            end
            if (lsu_busy && lsu_done) begin
                lsu_busy = 1'b0;
                lsu_size = access_size(mask_q);
                compare("lsu_error", word_t'(lsu_size == 0), word_t'(lsu_error));
                if (lsu_size != 0 && write_q) begin
                    for (int i = 0; i < lsu_size; i++) begin
                        shadow[byte_slot(addr_q + addr_t'(i))] = wdata_q[i*8 +: 8];
                    end
                end else if (lsu_size != 0) begin
                    compare("lsu_rdata", shadow_read(addr_q, lsu_size), lsu_rdata);
                end
            end
            if (test_active && !fetch_busy && !lsu_busy) begin
                test_active = 1'b0;
                tests_run++;
                if (test_bad) tests_failed++;
                $display("%0s  %0s", test_bad ? "FAIL" : "pass", test_name);
            end
            if (fetch_req) begin
                fetch_busy = 1'b1;
                pc_q       = fetch_pc;
            end
            if (lsu_req) begin
                lsu_busy = 1'b1;
                write_q  = lsu_write;
                addr_q   = lsu_addr;
                wdata_q  = lsu_wdata;
                mask_q   = lsu_mask;
            end
            if (fetch_req || lsu_req) begin
                test_active = 1'b1;
                test_bad    = 1'b0;
            end
        end
    end

    always @(posedge run_done) begin
        $display("tests run: %0d, failed: %0d", tests_run, tests_failed);
    end

endmodule

// File: verif/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem import bus_pkg::*; ();

    typedef struct packed {
        logic [127:0] name;
        logic         use_fetch;
        logic         use_lsu;
        logic         write;
        addr_t        addr;
        word_t        data;
        strobe_t      mask;
        addr_t        pc;
    } entry_t;

    logic         clock;
    logic         reset;
    logic         fetch_req;
    addr_t        fetch_pc;
    logic         lsu_req;
    logic         lsu_write;
    addr_t        lsu_addr;
    word_t        lsu_wdata;
    strobe_t      lsu_mask;
    logic         fetch_done;
    logic         fetch_error;
    word_t        instruction;
    logic         lsu_done;
    logic         lsu_error;
    word_t        lsu_rdata;
    logic [127:0] test_name;
    logic         run_done;
    int           tests_failed;
    entry_t       tests [$];

    mem_subsystem_top uut (
        .clock(clock), .reset(reset),
        .fetch_req(fetch_req), .fetch_pc(fetch_pc),
        .lsu_req(lsu_req), .lsu_write(lsu_write), .lsu_addr(lsu_addr),
        .lsu_wdata(lsu_wdata), .lsu_mask(lsu_mask),
        .fetch_done(fetch_done), .fetch_error(fetch_error), .instruction(instruction),
        .lsu_done(lsu_done), .lsu_error(lsu_error), .lsu_rdata(lsu_rdata)
    );

    mem_checker u_checker (
        .clock(clock), .reset(reset), .test_name(test_name),
        .fetch_req(fetch_req), .fetch_pc(fetch_pc),
        .lsu_req(lsu_req), .lsu_write(lsu_write), .lsu_addr(lsu_addr),
        .lsu_wdata(lsu_wdata), .lsu_mask(lsu_mask),
        .fetch_done(fetch_done), .fetch_error(fetch_error), .instruction(instruction),
        .lsu_done(lsu_done), .lsu_error(lsu_error), .lsu_rdata(lsu_rdata),
        .run_done(run_done), .tests_failed(tests_failed)
    );

    bind bus_arbiter mem_subsystem_asserts u_asserts (
        .clock(clock), .reset(reset), .fetch_grant(fetch_grant), .lsu_grant(lsu_grant),
        .mem_req_valid(mem_req_valid), .credits(credits)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic add_entry(input logic [127:0] name, input logic use_fetch,
                             input logic use_lsu, input logic write, input addr_t addr,
                             input strobe_t mask, input addr_t pc);
        entry_t e;
        e.name      = name;
        e.use_fetch = use_fetch;
        e.use_lsu   = use_lsu;
        e.write     = write;
        e.addr      = addr;
        e.data      = $urandom();
        e.mask      = mask;
        e.pc        = pc;
        tests.push_back(e);
    endtask

    // ============================================================
    // stimulus table: name, fetch, lsu, write, addr, mask, pc
    // ============================================================
    task automatic build_table();
        add_entry("st_word",      0, 1, 1, 32'h10, MASK_WORD, 32'h0);
        add_entry("ld_word",      0, 1, 0, 32'h10, MASK_WORD, 32'h0);
        add_entry("fetch_word",   1, 0, 0, 32'h0,  MASK_WORD, 32'h10);
        add_entry("st_base_20",   0, 1, 1, 32'h20, MASK_WORD, 32'h0);
        add_entry("st_byte_o1",   0, 1, 1, 32'h21, MASK_BYTE, 32'h0);
        add_entry("st_byte_o3",   0, 1, 1, 32'h23, MASK_BYTE, 32'h0);
        add_entry("ld_merge_20",  0, 1, 0, 32'h20, MASK_WORD, 32'h0);
        add_entry("st_base_24",   0, 1, 1, 32'h24, MASK_WORD, 32'h0);
        add_entry("st_byte_o0",   0, 1, 1, 32'h24, MASK_BYTE, 32'h0);
        add_entry("st_byte_o2",   0, 1, 1, 32'h26, MASK_BYTE, 32'h0);
        add_entry("ld_merge_24",  0, 1, 0, 32'h24, MASK_WORD, 32'h0);
        add_entry("st_base_30",   0, 1, 1, 32'h30, MASK_WORD, 32'h0);
        add_entry("st_base_34",   0, 1, 1, 32'h34, MASK_WORD, 32'h0);
        add_entry("st_half_o0",   0, 1, 1, 32'h30, MASK_HALF, 32'h0);
        add_entry("st_half_o1",   0, 1, 1, 32'h31, MASK_HALF, 32'h0);
        add_entry("st_half_o2",   0, 1, 1, 32'h32, MASK_HALF, 32'h0);
        add_entry("st_half_o3",   0, 1, 1, 32'h33, MASK_HALF, 32'h0);   // spills into 0x34.
        add_entry("ld_merge_30",  0, 1, 0, 32'h30, MASK_WORD, 32'h0);
        add_entry("ld_merge_34",  0, 1, 0, 32'h34, MASK_WORD, 32'h0);
        add_entry("st_base_40",   0, 1, 1, 32'h40, MASK_WORD, 32'h0);
        add_entry("st_base_44",   0, 1, 1, 32'h44, MASK_WORD, 32'h0);
        add_entry("ld_word_o1",   0, 1, 0, 32'h41, MASK_WORD, 32'h0);
        add_entry("ld_word_o3",   0, 1, 0, 32'h43, MASK_WORD, 32'h0);
        add_entry("ld_half_o3",   0, 1, 0, 32'h43, MASK_HALF, 32'h0);
        add_entry("ld_byte_o2",   0, 1, 0, 32'h42, MASK_BYTE, 32'h0);
        add_entry("st_word_o2",   0, 1, 1, 32'h22, MASK_WORD, 32'h0);
        add_entry("ld_check_20",  0, 1, 0, 32'h20, MASK_WORD, 32'h0);
        add_entry("ld_check_24",  0, 1, 0, 32'h24, MASK_WORD, 32'h0);
        add_entry("dual_st_50",   1, 1, 1, 32'h50, MASK_WORD, 32'h10);
        add_entry("dual_st_54",   1, 1, 1, 32'h54, MASK_WORD, 32'h20);
        add_entry("dual_ld_50",   1, 1, 0, 32'h50, MASK_WORD, 32'h24);
        add_entry("dual_st_53",   1, 1, 1, 32'h53, MASK_HALF, 32'h30);
        add_entry("dual_ld_53",   1, 1, 0, 32'h53, MASK_WORD, 32'h34);
        add_entry("dual_ld_41",   1, 1, 0, 32'h41, MASK_HALF, 32'h40);
        add_entry("fetch_pc_12",  1, 0, 0, 32'h0,  MASK_WORD, 32'h12);
        add_entry("fetch_after",  1, 0, 0, 32'h0,  MASK_WORD, 32'h10);
        add_entry("bad_mask",     0, 1, 1, 32'h40, 4'b0101,   32'h0);
        add_entry("ld_after_bad", 0, 1, 0, 32'h40, MASK_WORD, 32'h0);
        add_entry("dual_errors",  1, 1, 1, 32'h44, 4'b0110,   32'h13);
        add_entry("ld_after_two", 0, 1, 0, 32'h44, MASK_WORD, 32'h0);
    endtask

    task automatic run_entry(input entry_t e);
        logic got_fetch;
        logic got_lsu;
        @(negedge clock);
        test_name = e.name;
        fetch_req = e.use_fetch;
        fetch_pc  = e.pc;
        lsu_req   = e.use_lsu;
        lsu_write = e.write;
        lsu_addr  = e.addr;
        lsu_wdata = e.data;
        lsu_mask  = e.mask;
        @(negedge clock);
        fetch_req = 1'b0;   // one-cycle request pulse.
        lsu_req   = 1'b0;
        got_fetch = !e.use_fetch || fetch_done;
        got_lsu   = !e.use_lsu || lsu_done;
        while (!(got_fetch && got_lsu)) begin
            @(negedge clock);
            got_fetch = got_fetch || fetch_done;
            got_lsu   = got_lsu || lsu_done;
        end
    endtask

    initial begin
        reset      = 1'b1;
        fetch_req  = 1'b0;
        fetch_pc   = '0;
        lsu_req    = 1'b0;
        lsu_write  = 1'b0;
        lsu_addr   = '0;
        lsu_wdata  = '0;
        lsu_mask   = MASK_WORD;
        run_done   = 1'b0;
        test_name  = "reset";
        void'($urandom(32'h3eb1d7f9));
        build_table();
        repeat (8) @(negedge clock);
        reset = 1'b0;
        foreach (tests[i]) run_entry(tests[i]);
        repeat (2) @(negedge clock);
        run_done = 1'b1;
        #1;
        if (tests_failed == 0 && uut.u_arbiter.u_asserts.assert_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog, 40 cycles per table entry.
    initial begin
        @(negedge reset);
        repeat (tests.size() * 40) @(posedge clock);
        $display("timeout: %0d table entries did not finish in time", tests.size());
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: vlog.f
hw/bus_pkg.sv
hw/fetch_port.sv
hw/lsu_splitter.sv
hw/bus_arbiter.sv
hw/word_memory.sv
hw/mem_subsystem_top.sv
verif/mem_subsystem_asserts.sv
verif/mem_checker.sv
verif/tb_mem_subsystem.sv

// File: Makefile
TOP := tb_mem_subsystem
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
